/* logic/bridge_cfg.svh */
`ifndef BRIDGE_CFG_SVH
`define BRIDGE_CFG_SVH

// bus widths
`define BRIDGE_ADDR_W 32
`define BRIDGE_DATA_W 32
`define BRIDGE_ID_W 4

// words per refill line
`define BRIDGE_INST_WORDS 8
`define BRIDGE_DATA_WORDS 4

// AXI IDs per requester, used to route R beats back
`define BRIDGE_INST_ID 0
`define BRIDGE_DATA_ID 1

// fixed AR encodings
`define BRIDGE_BURST_INCR 1
`define BRIDGE_SIZE_WORD 2

`endif

/* logic/bridge_pkg.sv */
`default_nettype none

`include "bridge_cfg.svh"

package bridge_pkg;

    // data cache read kind
    typedef enum logic [0:0] {
        RD_WORD = 1'b0,
        RD_LINE = 1'b1
    } rd_type_e;

    // shared by both refill engines
    typedef enum logic [1:0] {
        REFILL_IDLE = 2'd0,
        REFILL_ADDR = 2'd1,
        REFILL_DATA = 2'd2,
        REFILL_DONE = 2'd3
    } refill_state_e;

    // engine to arbiter
    typedef struct packed {
        logic                      valid;
        logic [`BRIDGE_ADDR_W-1:0] addr;
        logic [7:0]                len;
        logic [`BRIDGE_ID_W-1:0]   id;
    } ar_req_t;

    // AR channel as driven on the bus
    typedef struct packed {
        logic [`BRIDGE_ID_W-1:0]   id;
        logic [`BRIDGE_ADDR_W-1:0] addr;
        logic [7:0]                len;
        logic [2:0]                size;
        logic [1:0]                burst;
        logic                      valid;
    } ar_chan_t;

    // one R beat
    typedef struct packed {
        logic                      valid;
        logic [`BRIDGE_ID_W-1:0]   id;
        logic [`BRIDGE_DATA_W-1:0] data;
        logic [1:0]                resp;
        logic                      last;
    } r_beat_t;

    // word 0 sits in the low bits
    typedef logic [`BRIDGE_INST_WORDS-1:0][`BRIDGE_DATA_W-1:0] inst_line_t;
    typedef logic [`BRIDGE_DATA_WORDS-1:0][`BRIDGE_DATA_W-1:0] data_line_t;

endpackage

`default_nettype wire

/* logic/inst_refill_ctrl.sv */
`timescale 1ns/1ns
`default_nettype none

`include "bridge_cfg.svh"

module inst_refill_ctrl
    import bridge_pkg::*;
(
    input  wire                       aclk,
    input  wire                       arst_n,
    input  wire                       rd_req,
    input  wire [`BRIDGE_ADDR_W-1:0]  rd_addr,
    input  wire                       ar_grant,
    input  wire r_beat_t              r_beat,
    output logic                      rd_rdy,
    output ar_req_t                   ar_req,
    output logic                      ret_valid,
    output inst_line_t                ret_data
);

    localparam int CNT_W      = $clog2(`BRIDGE_INST_WORDS);
    localparam int LINE_OFS_W = $clog2(`BRIDGE_INST_WORDS * (`BRIDGE_DATA_W / 8));

    refill_state_e             state;
    logic [CNT_W-1:0]          beat_cnt;
    logic [`BRIDGE_ADDR_W-1:0] line_addr;
    inst_line_t                line_buf;

    // new request only taken when idle
    assign rd_rdy = (state == REFILL_IDLE);

    assign ar_req.valid = (state == REFILL_ADDR);
    assign ar_req.addr  = line_addr;
    assign ar_req.len   = 8'(`BRIDGE_INST_WORDS - 1);
    assign ar_req.id    = `BRIDGE_ID_W'(`BRIDGE_INST_ID);

    assign ret_data = line_buf;

    always_ff @(posedge aclk or negedge arst_n) begin
        if (!arst_n) begin
            state     <= REFILL_IDLE;
            beat_cnt  <= '0;
            ret_valid <= 1'b0;
        end else begin
            ret_valid <= 1'b0;
            case (state)
                REFILL_IDLE: begin
                    if (rd_req) begin
                        state <= REFILL_ADDR;
                    end
                end
                REFILL_ADDR: begin
                    // wait for the arbiter to win the AR slot
                    if (ar_grant) begin
                        state    <= REFILL_DATA;
                        beat_cnt <= '0;
                    end
                end
                REFILL_DATA: begin
                    if (r_beat.valid) begin
                        beat_cnt <= beat_cnt + 1'b1;
                        if (r_beat.last) begin
                            state <= REFILL_DONE;
                        end
                    end
                end
                REFILL_DONE: begin
                    ret_valid <= 1'b1;
                    state     <= REFILL_IDLE;
                end
                default: begin
                    state <= REFILL_IDLE;
                end
            endcase
        end
    end

    // line address and beat storage
    always_ff @(posedge aclk) begin
        if (state == REFILL_IDLE && rd_req) begin
            line_addr <= {rd_addr[`BRIDGE_ADDR_W-1:LINE_OFS_W], {LINE_OFS_W{1'b0}}};
        end
        if (state == REFILL_DATA && r_beat.valid) begin
            line_buf[beat_cnt] <= r_beat.data;
        end
    end

endmodule

`default_nettype wire

/* logic/data_refill_ctrl.sv */
`timescale 1ns/1ns
`default_nettype none

`include "bridge_cfg.svh"

module data_refill_ctrl
    import bridge_pkg::*;
(
    input  wire                       aclk,
    input  wire                       arst_n,
    input  wire                       rd_req,
    input  wire rd_type_e             rd_type,
    input  wire [`BRIDGE_ADDR_W-1:0]  rd_addr,
    input  wire                       ar_grant,
    input  wire r_beat_t              r_beat,
    output logic                      rd_rdy,
    output ar_req_t                   ar_req,
    output logic                      ret_valid,
    output data_line_t                ret_data
);

    localparam int CNT_W      = $clog2(`BRIDGE_DATA_WORDS);
    localparam int WORD_OFS_W = $clog2(`BRIDGE_DATA_W / 8);
    localparam int LINE_OFS_W = $clog2(`BRIDGE_DATA_WORDS * (`BRIDGE_DATA_W / 8));

    refill_state_e             state;
    logic [CNT_W-1:0]          beat_cnt;
    rd_type_e                  type_q;
    logic [`BRIDGE_ADDR_W-1:0] req_addr;
    logic [`BRIDGE_ADDR_W-1:0] start_addr;
    data_line_t                line_buf;
    logic                      accept;

    assign rd_rdy = (state == REFILL_IDLE);
    assign accept = rd_rdy && rd_req;

    // line reads start on a 16-byte boundary, word reads on a word boundary
    always_comb begin
        if (rd_type == RD_LINE) begin
            start_addr = {rd_addr[`BRIDGE_ADDR_W-1:LINE_OFS_W], {LINE_OFS_W{1'b0}}};
        end else begin
            start_addr = {rd_addr[`BRIDGE_ADDR_W-1:WORD_OFS_W], {WORD_OFS_W{1'b0}}};
        end
    end

    assign ar_req.valid = (state == REFILL_ADDR);
    assign ar_req.addr  = req_addr;
    assign ar_req.len   = (type_q == RD_LINE) ? 8'(`BRIDGE_DATA_WORDS - 1) : 8'd0;
    assign ar_req.id    = `BRIDGE_ID_W'(`BRIDGE_DATA_ID);

    assign ret_data = line_buf;

    always_ff @(posedge aclk or negedge arst_n) begin
        if (!arst_n) begin
            state     <= REFILL_IDLE;
            beat_cnt  <= '0;
            ret_valid <= 1'b0;
        end else begin
            ret_valid <= 1'b0;
            case (state)
                REFILL_IDLE: begin
                    if (rd_req) begin
                        state <= REFILL_ADDR;
                    end
                end
                REFILL_ADDR: begin
                    if (ar_grant) begin
                        state    <= REFILL_DATA;
                        beat_cnt <= '0;
                    end
                end
                REFILL_DATA: begin
                    // single beat of a word read also carries last
                    if (r_beat.valid) begin
                        beat_cnt <= beat_cnt + 1'b1;
                        if (r_beat.last) begin
                            state <= REFILL_DONE;
                        end
                    end
                end
                REFILL_DONE: begin
                    ret_valid <= 1'b1;
                    state     <= REFILL_IDLE;
                end
                default: begin
                    state <= REFILL_IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge aclk) begin
        if (accept) begin
            type_q   <= rd_type;
            req_addr <= start_addr;
            // words a word read never writes come back as zero
            line_buf <= '0;
        end else if (state == REFILL_DATA && r_beat.valid) begin
            line_buf[beat_cnt] <= r_beat.data;
        end
    end

endmodule

`default_nettype wire

/* logic/axi_rd_arbiter.sv */
`timescale 1ns/1ns
`default_nettype none

`include "bridge_cfg.svh"

module axi_rd_arbiter
    import bridge_pkg::*;
(
    input  wire          aclk,
    input  wire          arst_n,
    input  wire ar_req_t inst_ar,
    input  wire ar_req_t data_ar,
    input  wire          arready,
    input  wire r_beat_t r_in,
    output logic         inst_grant,
    output logic         data_grant,
    output ar_chan_t     ar_out,
    output r_beat_t      inst_r,
    output r_beat_t      data_r,
    output logic         rready
);

    logic    last_data;
    logic    ar_locked;
    logic    locked_data;
    logic    rr_data;
    logic    pick_data;
    logic    ar_fire;
    ar_req_t sel_req;
    logic    beat_fire;

    // data wins when alone, or when inst went last
    assign rr_data = data_ar.valid && (!inst_ar.valid || !last_data);

    // a stalled AR keeps its owner until the handshake
    assign pick_data = ar_locked ? locked_data : rr_data;
    assign sel_req   = pick_data ? data_ar : inst_ar;

    assign ar_out.id    = sel_req.id;
    assign ar_out.addr  = sel_req.addr;
    assign ar_out.len   = sel_req.len;
    assign ar_out.size  = 3'(`BRIDGE_SIZE_WORD);
    assign ar_out.burst = 2'(`BRIDGE_BURST_INCR);
    assign ar_out.valid = inst_ar.valid || data_ar.valid;

    assign ar_fire    = ar_out.valid && arready;
    assign inst_grant = ar_fire && !pick_data;
    assign data_grant = ar_fire && pick_data;

    always_ff @(posedge aclk or negedge arst_n) begin
        if (!arst_n) begin
            last_data   <= 1'b0;
            ar_locked   <= 1'b0;
            locked_data <= 1'b0;
        end else begin
            if (ar_fire) begin
                last_data <= pick_data;
            end
            if (ar_out.valid && !arready) begin
                ar_locked   <= 1'b1;
                locked_data <= pick_data;
            end else begin
                ar_locked <= 1'b0;
            end
        end
    end

    // engines never stall the R channel
    always_ff @(posedge aclk or negedge arst_n) begin
        if (!arst_n) begin
            rready <= 1'b0;
        end else begin
            rready <= 1'b1;
        end
    end

    assign beat_fire = r_in.valid && rready;

    // steer by rid
    always_comb begin
        inst_r       = r_in;
        data_r       = r_in;
        inst_r.valid = beat_fire && (r_in.id == `BRIDGE_ID_W'(`BRIDGE_INST_ID));
        data_r.valid = beat_fire && (r_in.id == `BRIDGE_ID_W'(`BRIDGE_DATA_ID));
    end

endmodule

`default_nettype wire

/* logic/cache_axi_rd_bridge.sv */
`timescale 1ns/1ns
`default_nettype none

`include "bridge_cfg.svh"

module cache_axi_rd_bridge
    import bridge_pkg::*;
(
    input  wire                       aclk,
    input  wire                       arst_n,

    // instruction cache refill port
    input  wire                       inst_rd_req,
    input  wire [`BRIDGE_ADDR_W-1:0]  inst_rd_addr,
    output logic                      inst_rd_rdy,
    output logic                      inst_ret_valid,
    output inst_line_t                inst_ret_data,

    // data cache read port
    input  wire                       data_rd_req,
    input  wire rd_type_e             data_rd_type,
    input  wire [`BRIDGE_ADDR_W-1:0]  data_rd_addr,
    output logic                      data_rd_rdy,
    output logic                      data_ret_valid,
    output data_line_t                data_ret_data,

    // AXI read address
    output logic [`BRIDGE_ID_W-1:0]   arid,
    output logic [`BRIDGE_ADDR_W-1:0] araddr,
    output logic [7:0]                arlen,
    output logic [2:0]                arsize,
    output logic [1:0]                arburst,
    output logic                      arvalid,
    input  wire                       arready,

    // AXI read data
    input  wire [`BRIDGE_ID_W-1:0]    rid,
    input  wire [`BRIDGE_DATA_W-1:0]  rdata,
    input  wire [1:0]                 rresp,
    input  wire                       rlast,
    input  wire                       rvalid,
    output logic                      rready
);

    ar_req_t  inst_ar;
    ar_req_t  data_ar;
    logic     inst_grant;
    logic     data_grant;
    ar_chan_t ar_out;
    r_beat_t  r_in;
    r_beat_t  inst_r;
    r_beat_t  data_r;

    assign r_in.valid = rvalid;
    assign r_in.id    = rid;
    assign r_in.data  = rdata;
    assign r_in.resp  = rresp;
    assign r_in.last  = rlast;

    assign arid    = ar_out.id;
    assign araddr  = ar_out.addr;
    assign arlen   = ar_out.len;
    assign arsize  = ar_out.size;
    assign arburst = ar_out.burst;
    assign arvalid = ar_out.valid;

    inst_refill_ctrl u_inst_refill (
        .aclk      (aclk),
        .arst_n    (arst_n),
        .rd_req    (inst_rd_req),
        .rd_addr   (inst_rd_addr),
        .ar_grant  (inst_grant),
        .r_beat    (inst_r),
        .rd_rdy    (inst_rd_rdy),
        .ar_req    (inst_ar),
        .ret_valid (inst_ret_valid),
        .ret_data  (inst_ret_data)
    );

    data_refill_ctrl u_data_refill (
        .aclk      (aclk),
        .arst_n    (arst_n),
        .rd_req    (data_rd_req),
        .rd_type   (data_rd_type),
        .rd_addr   (data_rd_addr),
        .ar_grant  (data_grant),
        .r_beat    (data_r),
        .rd_rdy    (data_rd_rdy),
        .ar_req    (data_ar),
        .ret_valid (data_ret_valid),
        .ret_data  (data_ret_data)
    );

    axi_rd_arbiter u_rd_arbiter (
        .aclk       (aclk),
        .arst_n     (arst_n),
        .inst_ar    (inst_ar),
        .data_ar    (data_ar),
        .arready    (arready),
        .r_in       (r_in),
        .inst_grant (inst_grant),
        .data_grant (data_grant),
        .ar_out     (ar_out),
        .inst_r     (inst_r),
        .data_r     (data_r),
        .rready     (rready)
    );

endmodule

`default_nettype wire

/* verification/tb_axi_mem.sv */
`timescale 1ns/1ns
`default_nettype none

`include "bridge_cfg.svh"

module tb_axi_mem #(
    parameter logic [31:0] SEED = 32'hb3f8
) (
    input  wire                       aclk,
    input  wire                       arst_n,
    input  wire [`BRIDGE_ID_W-1:0]    arid,
    input  wire [`BRIDGE_ADDR_W-1:0]  araddr,
    input  wire [7:0]                 arlen,
    input  wire                       arvalid,
    output logic                      arready,
    output logic [`BRIDGE_ID_W-1:0]   rid,
    output logic [`BRIDGE_DATA_W-1:0] rdata,
    output logic [1:0]                rresp,
    output logic                      rlast,
    output logic                      rvalid,
    input  wire                       rready
);

    // one accepted AR burst
    typedef struct packed {
        logic [`BRIDGE_ID_W-1:0]   id;
        logic [`BRIDGE_ADDR_W-1:0] addr;
        logic [7:0]                len;
    } burst_t;

    burst_t                    burst_q[$];
    burst_t                    head;
    integer                    seed = SEED;
    int                        beat_idx;
    logic [`BRIDGE_ADDR_W-1:0] beat_addr;

    always @(posedge aclk or negedge arst_n) begin
        if (!arst_n) begin
            arready <= 1'b0;
            rvalid  <= 1'b0;
            rid     <= '0;
            rdata   <= '0;
            rresp   <= 2'b00;
            rlast   <= 1'b0;
            burst_q.delete();
            beat_idx = 0;
        end else begin
            // ready about half the time, so stalls of several cycles happen
            arready <= ($random(seed) & 32'h1) != 0;
            if (arvalid && arready) begin
                burst_q.push_back({arid, araddr, arlen});
            end

            if (rvalid && rready) begin
                if (rlast) begin
                    burst_q.delete(0);
                    beat_idx = 0;
                end else begin
                    beat_idx = beat_idx + 1;
                end
            end

            // bursts come back whole and in AR order
            if (!rvalid || rready) begin
                if (burst_q.size() != 0 && ($random(seed) & 32'h3) != 0) begin
                    head      = burst_q[0];
                    beat_addr = head.addr + 32'(beat_idx * (`BRIDGE_DATA_W / 8));
                    rvalid <= 1'b1;
                    rid    <= head.id;
                    // memory word at byte address A holds ~A
                    rdata  <= ~beat_addr;
                    rresp  <= 2'b00;
                    rlast  <= (beat_idx == int'(head.len));
                end else begin
                    rvalid <= 1'b0;
                end
            end
        end
    end

endmodule

`default_nettype wire

/* verification/tb_cache_axi_rd_bridge.sv */
`timescale 1ns/1ns
`default_nettype none

`include "bridge_cfg.svh"

module tb_cache_axi_rd_bridge
    import bridge_pkg::*;
();

    localparam time CLK_PERIOD = 100;
    localparam int  N_INST     = 100;
    localparam int  N_DATA     = 100;
    localparam int  NUM_REQ    = N_INST + N_DATA;
    localparam time TIMEOUT    = NUM_REQ * 40 * CLK_PERIOD;

    logic                      aclk;
    logic                      arst_n;
    logic                      inst_rd_req;
    logic [`BRIDGE_ADDR_W-1:0] inst_rd_addr;
    logic                      inst_rd_rdy;
    logic                      inst_ret_valid;
    inst_line_t                inst_ret_data;
    logic                      data_rd_req;
    rd_type_e                  data_rd_type;
    logic [`BRIDGE_ADDR_W-1:0] data_rd_addr;
    logic                      data_rd_rdy;
    logic                      data_ret_valid;
    data_line_t                data_ret_data;
    logic [`BRIDGE_ID_W-1:0]   arid;
    logic [`BRIDGE_ADDR_W-1:0] araddr;
    logic [7:0]                arlen;
    logic [2:0]                arsize;
    logic [1:0]                arburst;
    logic                      arvalid;
    logic                      arready;
    logic [`BRIDGE_ID_W-1:0]   rid;
    logic [`BRIDGE_DATA_W-1:0] rdata;
    logic [1:0]                rresp;
    logic                      rlast;
    logic                      rvalid;
    logic                      rready;

    integer     seed = 32'hb3f8;
    ar_chan_t   ar_now;
    ar_chan_t   ar_held;
    logic       ar_stalled;
    rd_type_e   ar_type;
    int         inst_ret_cnt;
    int         data_ret_cnt;

    // expected traffic per requester, oldest first
    ar_chan_t   inst_ar_q[$];
    inst_line_t inst_line_q[$];
    ar_chan_t   data_ar_q[$];
    rd_type_e   data_type_q[$];
    data_line_t data_line_q[$];

    assign ar_now = {arid, araddr, arlen, arsize, arburst, arvalid};

    cache_axi_rd_bridge dut0 (
        .aclk           (aclk),
        .arst_n         (arst_n),
        .inst_rd_req    (inst_rd_req),
        .inst_rd_addr   (inst_rd_addr),
        .inst_rd_rdy    (inst_rd_rdy),
        .inst_ret_valid (inst_ret_valid),
        .inst_ret_data  (inst_ret_data),
        .data_rd_req    (data_rd_req),
        .data_rd_type   (data_rd_type),
        .data_rd_addr   (data_rd_addr),
        .data_rd_rdy    (data_rd_rdy),
        .data_ret_valid (data_ret_valid),
        .data_ret_data  (data_ret_data),
        .arid           (arid),
        .araddr         (araddr),
        .arlen          (arlen),
        .arsize         (arsize),
        .arburst        (arburst),
        .arvalid        (arvalid),
        .arready        (arready),
        .rid            (rid),
        .rdata          (rdata),
        .rresp          (rresp),
        .rlast          (rlast),
        .rvalid         (rvalid),
        .rready         (rready)
    );

    tb_axi_mem #(
        .SEED (32'hb3f8)
    ) mem0 (
        .aclk    (aclk),
        .arst_n  (arst_n),
        .arid    (arid),
        .araddr  (araddr),
        .arlen   (arlen),
        .arvalid (arvalid),
        .arready (arready),
        .rid     (rid),
        .rdata   (rdata),
        .rresp   (rresp),
        .rlast   (rlast),
        .rvalid  (rvalid),
        .rready  (rready)
    );

    initial begin
        aclk = 1'b0;
        forever #(CLK_PERIOD / 2) aclk = ~aclk;
    end

    task automatic abort_run();
        $display("Verification failed");
        $fatal(1, "stopped at first error");
    endtask

    task automatic ar_chan_check(string name, ar_chan_t got, ar_chan_t exp);
        if (got !== exp) begin
            $display("Mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
            abort_run();
        end
    endtask

    task automatic inst_line_check(string name, inst_line_t got, inst_line_t exp);
        if (got !== exp) begin
            $display("Mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
            abort_run();
        end
    endtask

    task automatic data_line_check(string name, data_line_t got, data_line_t exp);
        if (got !== exp) begin
            $display("Mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
            abort_run();
        end
    endtask

    task automatic rd_type_check(string name, rd_type_e got, rd_type_e exp);
        if (got !== exp) begin
            $display("Mismatch at %0t: %s got %0d expected %0d", $time, name, got, exp);
            abort_run();
        end
    endtask

    // memory word at byte address A is ~A
    function automatic inst_line_t inst_line_at(logic [31:0] base);
        inst_line_t line;
        for (int i = 0; i < `BRIDGE_INST_WORDS; i++) begin
            line[i] = ~(base + 32'(4 * i));
        end
        return line;
    endfunction

    function automatic data_line_t data_line_at(logic [31:0] base, rd_type_e kind);
        data_line_t line;
        line = '0;
        if (kind == RD_LINE) begin
            for (int i = 0; i < `BRIDGE_DATA_WORDS; i++) begin
                line[i] = ~(base + 32'(4 * i));
            end
        end else begin
            line[0] = ~base;
        end
        return line;
    endfunction

    task automatic inst_requester();
        logic [31:0] addr;
        ar_chan_t    ar_exp;
        int          gap;
        for (int n = 0; n < N_INST; n++) begin
            addr         = $random(seed);
            gap          = ($random(seed) & 32'h7) + 1;
            ar_exp.id    = `BRIDGE_ID_W'(`BRIDGE_INST_ID);
            ar_exp.addr  = addr & ~32'h1f;
            ar_exp.len   = 8'(`BRIDGE_INST_WORDS - 1);
            ar_exp.size  = 3'(`BRIDGE_SIZE_WORD);
            ar_exp.burst = 2'(`BRIDGE_BURST_INCR);
            ar_exp.valid = 1'b1;
            repeat (gap) @(posedge aclk);
            inst_rd_req  <= 1'b1;
            inst_rd_addr <= addr;
            @(posedge aclk);
            while (!inst_rd_rdy) @(posedge aclk);
            inst_ar_q.push_back(ar_exp);
            inst_line_q.push_back(inst_line_at(ar_exp.addr));
            inst_rd_req <= 1'b0;
            @(posedge aclk);
            while (!inst_ret_valid) @(posedge aclk);
        end
    endtask

    task automatic data_requester();
        logic [31:0] addr;
        rd_type_e    kind;
        ar_chan_t    ar_exp;
        int          gap;
        for (int n = 0; n < N_DATA; n++) begin
            addr = $random(seed);
            gap  = ($random(seed) & 32'h7) + 1;
            if (($random(seed) & 32'h1) != 0) begin
                kind        = RD_LINE;
                ar_exp.addr = addr & ~32'hf;
                ar_exp.len  = 8'(`BRIDGE_DATA_WORDS - 1);
            end else begin
                kind        = RD_WORD;
                ar_exp.addr = addr & ~32'h3;
                ar_exp.len  = 8'd0;
            end
            ar_exp.id    = `BRIDGE_ID_W'(`BRIDGE_DATA_ID);
            ar_exp.size  = 3'(`BRIDGE_SIZE_WORD);
            ar_exp.burst = 2'(`BRIDGE_BURST_INCR);
            ar_exp.valid = 1'b1;
            repeat (gap) @(posedge aclk);
            data_rd_req  <= 1'b1;
            data_rd_type <= kind;
            data_rd_addr <= addr;
            @(posedge aclk);
            while (!data_rd_rdy) @(posedge aclk);
            data_ar_q.push_back(ar_exp);
            data_type_q.push_back(kind);
            data_line_q.push_back(data_line_at(ar_exp.addr, kind));
            data_rd_req <= 1'b0;
            @(posedge aclk);
            while (!data_ret_valid) @(posedge aclk);
        end
    endtask

    // AR fields frozen during a stall, and each handshake matched to its requester
    always @(posedge aclk) begin
        if (arst_n) begin
            if (ar_stalled) begin
                ar_chan_check("ar channel during stall", ar_now, ar_held);
            end
            ar_stalled = arvalid && !arready;
            ar_held    = ar_now;
            if (arvalid && arready) begin
                if (arid == `BRIDGE_ID_W'(`BRIDGE_INST_ID)) begin
                    if (inst_ar_q.size() == 0) begin
                        $display("Error at %0t: instruction AR with no pending request", $time);
                        abort_run();
                    end else begin
                        ar_chan_check("inst ar channel", ar_now, inst_ar_q.pop_front());
                    end
                end else if (arid == `BRIDGE_ID_W'(`BRIDGE_DATA_ID)) begin
                    if (data_ar_q.size() == 0) begin
                        $display("Error at %0t: data AR with no pending request", $time);
                        abort_run();
                    end else begin
                        // burst length tells which read kind the bridge issued
                        if (arlen == 8'd0) begin
                            ar_type = RD_WORD;
                        end else begin
                            ar_type = RD_LINE;
                        end
                        rd_type_check("data read type", ar_type, data_type_q.pop_front());
                        ar_chan_check("data ar channel", ar_now, data_ar_q.pop_front());
                    end
                end else begin
                    $display("Error at %0t: AR handshake with unknown arid %0d", $time, arid);
                    abort_run();
                end
            end
        end
    end

    always @(posedge aclk) begin
        if (arst_n && inst_ret_valid) begin
            if (inst_line_q.size() == 0) begin
                $display("Error at %0t: inst_ret_valid without a pending request", $time);
                abort_run();
            end else begin
                inst_line_check("inst_ret_data", inst_ret_data, inst_line_q.pop_front());
                inst_ret_cnt = inst_ret_cnt + 1;
            end
        end
        if (arst_n && data_ret_valid) begin
            if (data_line_q.size() == 0) begin
                $display("Error at %0t: data_ret_valid without a pending request", $time);
                abort_run();
            end else begin
                data_line_check("data_ret_data", data_ret_data, data_line_q.pop_front());
                data_ret_cnt = data_ret_cnt + 1;
            end
        end
    end

    initial begin
        #(TIMEOUT);
        $display("Error: watchdog expired at %0t before all requests returned", $time);
        abort_run();
    end

    initial begin
        arst_n       = 1'b0;
        inst_rd_req  = 1'b0;
        inst_rd_addr = '0;
        data_rd_req  = 1'b0;
        data_rd_type = RD_WORD;
        data_rd_addr = '0;
        ar_stalled   = 1'b0;
        ar_held      = '0;
        ar_type      = RD_WORD;
        inst_ret_cnt = 0;
        data_ret_cnt = 0;
        repeat (4) @(posedge aclk);
        if (arvalid || inst_ret_valid || data_ret_valid || rready
                || !inst_rd_rdy || !data_rd_rdy) begin
            $display("Error at %0t: outputs not at their reset values", $time);
            abort_run();
        end
        arst_n <= 1'b1;

        // both engines busy at once
        fork
            inst_requester();
            data_requester();
        join
        repeat (4) @(posedge aclk);

        if (inst_ret_cnt == N_INST && data_ret_cnt == N_DATA
                && inst_ar_q.size() == 0 && data_ar_q.size() == 0
                && inst_line_q.size() == 0 && data_line_q.size() == 0) begin
            $display("Verification passed");
            $finish;
        end else begin
            $display("Error at %0t: %0d inst and %0d data returns, %0d and %0d expected",
                     $time, inst_ret_cnt, data_ret_cnt, N_INST, N_DATA);
            abort_run();
        end
    end

endmodule

`default_nettype wire

/* flist.f */
+incdir+logic
logic/bridge_pkg.sv
logic/inst_refill_ctrl.sv
logic/data_refill_ctrl.sv
logic/axi_rd_arbiter.sv
logic/cache_axi_rd_bridge.sv
verification/tb_axi_mem.sv
verification/tb_cache_axi_rd_bridge.sv

/* Bender.yml */
package:
  name: cache_axi_rd_bridge

sources:
  - include_dirs:
      - logic
    files:
      - logic/bridge_pkg.sv
      - logic/inst_refill_ctrl.sv
      - logic/data_refill_ctrl.sv
      - logic/axi_rd_arbiter.sv
      - logic/cache_axi_rd_bridge.sv
  - target: test
    include_dirs:
      - logic
    files:
      - verification/tb_axi_mem.sv
      - verification/tb_cache_axi_rd_bridge.sv
